//--- cnn_accel.f
verilog/cnn_reg_pkg.sv
verilog/cnn_dp_pkg.sv
verilog/cnn_reg_bank.sv
verilog/cnn_layer_fsm.sv
verilog/cnn_scan_counter.sv
verilog/cnn_img_buf.sv
verilog/cnn_conv_mac.sv
verilog/cnn_accel_top.sv
verif/cnn_accel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile the testbench with verilator, run it, then search the log for the pass line

ROOT="$(cd "$(dirname "$0")" && pwd)"
cd "$ROOT" || exit 1

BUILD=obj_dir
LOG=sim.log
TOP=cnn_accel_tb

verilator --binary --timing --assert \
	-f cnn_accel.f \
	--top-module "$TOP" \
	-Mdir "$BUILD" \
	-o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx -- '>>> PASS' "$LOG"; then
	echo "simulation finished cleanly"
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

//--- verif/cnn_accel_tb.sv
module cnn_accel_tb;

	localparam int CLK_PERIOD = 8;
	localparam int SEED = 32'h1f4bf3fa;
	// delays used by every layer run here
	localparam int START_DLY = 10;
	localparam int ROW_DLY = 3;
	localparam int MARGIN = 2000;
	localparam int IMG_BASE = 1 << cnn_reg_pkg::IMG_SEL_BIT;

	// cycles from start pulse to the end of DONE
	function automatic int layer_len(input int w, input int h);
		// three drain cycles plus the done cycle
		return START_DLY + h * (ROW_DLY + cnn_dp_pkg::N_TAPS * w) + 4;
	endfunction

	// three 8x8 layers, then 5x7 and 7x5
	localparam int WATCHDOG_CYCLES =
		3 * layer_len(8, 8) + layer_len(5, 7) + layer_len(7, 5) + MARGIN;

	logic clk = 1'b0;
	logic rstn;
	logic bus_wr;
	logic [cnn_reg_pkg::BUS_ADDR_W-1:0] bus_addr;
	logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_wdata;
	logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_rdata;
	logic [cnn_dp_pkg::PIX_W-1:0] out_pixel;
	logic out_valid;

	// host copy of image and kernel
	int img [cnn_dp_pkg::IMG_DEPTH];
	int kern [cnn_dp_pkg::N_TAPS];
	logic [cnn_dp_pkg::PIX_W-1:0] got_q [$];
	string test_name;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;

	cnn_accel_top u_dut (
		.clk(clk),
		.rstn(rstn),
		.bus_wr_i(bus_wr),
		.bus_addr_i(bus_addr),
		.bus_wdata_i(bus_wdata),
		.bus_rdata_o(bus_rdata),
		.out_pixel_o(out_pixel),
		.out_valid_o(out_valid)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// output capture and watchdog
	// ----------------------------------------
	// sampled mid cycle, valid is a registered strobe
	always @(negedge clk) begin
		if (out_valid)
			got_q.push_back(out_pixel);
	end

	// results come nine cycles apart, never back to back
	assert property (@(posedge clk) disable iff (!rstn) out_valid |=> !out_valid)
		else begin
			errors++;
			$display("out_valid_o stayed high for more than one cycle");
		end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
		$display(">>> FAIL");
		$finish;
	end

	// ----------------------------------------
	// host port tasks
	// ----------------------------------------
	function automatic logic [cnn_reg_pkg::BUS_ADDR_W-1:0] reg_addr(input logic [3:0] idx);
		return cnn_reg_pkg::BUS_ADDR_W'(idx);
	endfunction

	// one strobe, called on a falling edge
	task automatic write_word(input logic [cnn_reg_pkg::BUS_ADDR_W-1:0] addr,
			input logic [31:0] data);
		bus_wr = 1'b1;
		bus_addr = addr;
		bus_wdata = data;
		@(negedge clk);
		bus_wr = 1'b0;
	endtask

	// read data settles well before the next rising edge
	task automatic peek_word(input logic [cnn_reg_pkg::BUS_ADDR_W-1:0] addr,
			output logic [31:0] data);
		bus_addr = addr;
		#(CLK_PERIOD / 4);
		data = bus_rdata;
	endtask

	task automatic read_word(input logic [cnn_reg_pkg::BUS_ADDR_W-1:0] addr,
			output logic [31:0] data);
		peek_word(addr, data);
		@(negedge clk);
	endtask

	task automatic expect_eq(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		assert (actual == expected)
			else begin
				errors++;
				$display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
					test_name, what, expected, actual);
			end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %-16s %s, %0d errors", test_name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
	endtask

	// ----------------------------------------
	// register map expectations
	// ----------------------------------------
	function automatic logic [31:0] reset_value(input logic [3:0] idx);
		case (idx)
			cnn_reg_pkg::REG_WIDTH_HEIGHT:
				return 32'(cnn_reg_pkg::DEF_WIDTH | (cnn_reg_pkg::DEF_HEIGHT << 16));
			cnn_reg_pkg::REG_DELAYS:
				return 32'(cnn_reg_pkg::DEF_START_UP | (cnn_reg_pkg::DEF_HSYNC << 12));
			default: return '0;
		endcase
	endfunction

	// writable bits per index, START and DONE read back nothing written
	function automatic logic [31:0] reg_mask(input logic [3:0] idx);
		case (idx)
			cnn_reg_pkg::REG_WIDTH_HEIGHT: return 32'h003f_003f;
			cnn_reg_pkg::REG_DELAYS: return 32'h00ff_ffff;
			cnn_reg_pkg::REG_LAYER_CFG: return 32'h0000_001f;
			cnn_reg_pkg::REG_WEIGHT_LO: return 32'hffff_ffff;
			cnn_reg_pkg::REG_WEIGHT_HI: return 32'hffff_ffff;
			cnn_reg_pkg::REG_WEIGHT_CTR: return 32'h0000_00ff;
			default: return '0;
		endcase
	endfunction

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int ref_pixel(input int r, input int c, input int w, input int h,
			input cnn_dp_pkg::act_type_e act, input int shift);
		int acc;
		int rr;
		int cc;
		acc = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				rr = r + dr;
				cc = c + dc;
				// outside the frame counts as zero
				if (rr >= 0 && rr < h && cc >= 0 && cc < w)
					acc += img[rr * w + cc] * kern[(dr + 1) * 3 + dc + 1];
			end
		end
		acc = acc >>> shift;
		if (act == cnn_dp_pkg::ACT_RELU) begin
			if (acc < 0)
				acc = 0;
			else if (acc > 255)
				acc = 255;
		end else begin
			if (acc < -128)
				acc = -128;
			else if (acc > 127)
				acc = 127;
			// two's complement byte
			acc = acc & 255;
		end
		return acc;
	endfunction

	// ----------------------------------------
	// layer setup and run
	// ----------------------------------------
	task automatic set_layer(input int w, input int h, input cnn_dp_pkg::act_type_e act,
			input int shift);
		write_word(reg_addr(cnn_reg_pkg::REG_WIDTH_HEIGHT),
			w | (h << cnn_reg_pkg::HEIGHT_LSB));
		write_word(reg_addr(cnn_reg_pkg::REG_DELAYS),
			START_DLY | (ROW_DLY << cnn_reg_pkg::HSYNC_LSB));
		write_word(reg_addr(cnn_reg_pkg::REG_LAYER_CFG),
			int'(act) | (shift << cnn_reg_pkg::SHIFT_LSB));
		// tap 0 in the low byte
		write_word(reg_addr(cnn_reg_pkg::REG_WEIGHT_LO),
			{8'(kern[3]), 8'(kern[2]), 8'(kern[1]), 8'(kern[0])});
		write_word(reg_addr(cnn_reg_pkg::REG_WEIGHT_HI),
			{8'(kern[7]), 8'(kern[6]), 8'(kern[5]), 8'(kern[4])});
		write_word(reg_addr(cnn_reg_pkg::REG_WEIGHT_CTR), 32'(8'(kern[8])));
	endtask

	task automatic load_image(input int w, input int h, input int max_val);
		for (int i = 0; i < w * h; i++) begin
			img[i] = int'($urandom_range(max_val, 0));
			write_word(cnn_reg_pkg::BUS_ADDR_W'(IMG_BASE + i), 32'(img[i]));
		end
	endtask

	// restart_at below zero means no second start
	task automatic run_layer(input int w, input int h, input cnn_dp_pkg::act_type_e act,
			input int shift, input int restart_at);
		logic [31:0] rd;
		int cycles;
		bit done;
		got_q.delete();
		write_word(reg_addr(cnn_reg_pkg::REG_START), 32'd1);
		cycles = 0;
		done = 1'b0;
		while (!done && cycles <= layer_len(w, h) + 16) begin
			peek_word(reg_addr(cnn_reg_pkg::REG_DONE), rd);
			if (cycles == 0)
				expect_eq("DONE cleared by start", 32'd0, rd);
			else
				done = rd[0];
			if (!done) begin
				@(negedge clk);
				cycles++;
				if (cycles == restart_at) begin
					// busy layer ignores this
					write_word(reg_addr(cnn_reg_pkg::REG_START), 32'd1);
					cycles++;
				end
			end
		end
		@(negedge clk);
		if (!done) begin
			errors++;
			$display("%s: DONE not set within %0d cycles of start", test_name, cycles);
		end else begin
			expect_eq("cycles to DONE", layer_len(w, h) + 1, cycles);
		end
		expect_eq("output count", w * h, got_q.size());
		for (int r = 0; r < h; r++) begin
			for (int c = 0; c < w; c++) begin
				if (r * w + c < got_q.size())
					expect_eq($sformatf("pixel %0d,%0d", r, c),
						ref_pixel(r, c, w, h, act, shift), 32'(got_q[r * w + c]));
			end
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [31:0] rd;
		logic [31:0] data;
		int shift;
		int addr;
		void'($urandom(SEED));
		rstn = 1'b0;
		bus_wr = 1'b0;
		bus_addr = '0;
		bus_wdata = '0;
		repeat (3) @(negedge clk);
		rstn = 1'b1;
		@(negedge clk);

		begin_test("reset_defaults");
		for (int i = 0; i < 16; i++) begin
			read_word(reg_addr(4'(i)), rd);
			expect_eq($sformatf("register %0d", i), reset_value(4'(i)), rd);
		end
		expect_eq("outputs while idle", 32'd0, got_q.size());
		end_test();

		begin_test("reg_readback");
		for (int i = 0; i < 16; i++) begin
			data = $urandom;
			// keep the trigger bit clear, no layer here
			if (4'(i) == cnn_reg_pkg::REG_START)
				data[0] = 1'b0;
			write_word(reg_addr(4'(i)), data);
			read_word(reg_addr(4'(i)), rd);
			expect_eq($sformatf("register %0d", i), data & reg_mask(4'(i)), rd);
		end
		addr = IMG_BASE + int'($urandom_range(cnn_dp_pkg::IMG_DEPTH - 1, 0));
		write_word(cnn_reg_pkg::BUS_ADDR_W'(addr), $urandom);
		read_word(cnn_reg_pkg::BUS_ADDR_W'(addr), rd);
		expect_eq("image window read", 32'd0, rd);
		end_test();

		begin_test("identity");
		for (int t = 0; t < cnn_dp_pkg::N_TAPS; t++)
			kern[t] = 0;
		kern[4] = 1;
		set_layer(8, 8, cnn_dp_pkg::ACT_LINEAR, 0);
		load_image(8, 8, 127);
		run_layer(8, 8, cnn_dp_pkg::ACT_LINEAR, 0, -1);
		// identity passes pixels through in raster order
		for (int i = 0; i < 64 && i < got_q.size(); i++)
			expect_eq($sformatf("identity pixel %0d", i), img[i], 32'(got_q[i]));
		end_test();

		// one random kernel for both activations
		for (int t = 0; t < cnn_dp_pkg::N_TAPS; t++)
			kern[t] = int'($urandom_range(255, 0)) - 128;
		shift = int'($urandom_range(7, 0));

		begin_test("relu_kernel");
		set_layer(8, 8, cnn_dp_pkg::ACT_RELU, shift);
		load_image(8, 8, 255);
		run_layer(8, 8, cnn_dp_pkg::ACT_RELU, shift, -1);
		end_test();

		begin_test("linear_kernel");
		set_layer(8, 8, cnn_dp_pkg::ACT_LINEAR, shift);
		load_image(8, 8, 255);
		run_layer(8, 8, cnn_dp_pkg::ACT_LINEAR, shift, -1);
		end_test();

		begin_test("count_done");
		set_layer(5, 7, cnn_dp_pkg::ACT_RELU, shift);
		load_image(5, 7, 255);
		run_layer(5, 7, cnn_dp_pkg::ACT_RELU, shift, -1);
		read_word(reg_addr(cnn_reg_pkg::REG_DONE), rd);
		expect_eq("DONE after 5x7 layer", 32'd1, rd);
		// transposed size, second start in mid layer
		set_layer(7, 5, cnn_dp_pkg::ACT_RELU, shift);
		load_image(7, 5, 255);
		run_layer(7, 5, cnn_dp_pkg::ACT_RELU, shift, 100);
		read_word(reg_addr(cnn_reg_pkg::REG_DONE), rd);
		expect_eq("DONE after 7x5 layer", 32'd1, rd);
		end_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- verilog/cnn_accel_top.sv
module cnn_accel_top (
	input  logic clk,
	input  logic rstn,
	input  logic bus_wr_i,
	input  logic [cnn_reg_pkg::BUS_ADDR_W-1:0] bus_addr_i,
	input  logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_wdata_i,
	output logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_rdata_o,
	output logic [cnn_dp_pkg::PIX_W-1:0] out_pixel_o,
	output logic out_valid_o
);

	// ----------------------------------------
	// configuration
	// ----------------------------------------
	logic [cnn_dp_pkg::DIM_W-1:0] width;
	logic [cnn_dp_pkg::DIM_W-1:0] height;
	logic [cnn_reg_pkg::DELAY_W-1:0] start_up;
	logic [cnn_reg_pkg::DELAY_W-1:0] hsync;
	cnn_dp_pkg::act_type_e act_type;
	logic [cnn_reg_pkg::SHIFT_W-1:0] act_shift;
	logic [cnn_dp_pkg::N_TAPS*cnn_dp_pkg::WGT_W-1:0] weights;

	// image write path
	logic img_we;
	logic [cnn_dp_pkg::IMG_ADDR_W-1:0] img_waddr;
	logic [cnn_dp_pkg::PIX_W-1:0] img_wdata;

	// control
	logic start;
	logic layer_done;
	logic delay_end;
	logic frame_end;
	cnn_dp_pkg::layer_state_e state;

	// scan position
	logic [cnn_dp_pkg::DIM_W-1:0] row;
	logic [cnn_dp_pkg::DIM_W-1:0] col;
	logic [cnn_dp_pkg::TAP_W-1:0] tap;
	logic tap_vld;
	logic first_row;
	logic last_row;
	logic first_col;
	logic last_col;

	// tap pixel into the mac
	logic [cnn_dp_pkg::PIX_W-1:0] tap_pix;
	logic [cnn_dp_pkg::TAP_W-1:0] tap_d;
	logic tap_vld_d;

	cnn_reg_bank u_reg_bank (
		.clk(clk),
		.rstn(rstn),
		.bus_wr_i(bus_wr_i),
		.bus_addr_i(bus_addr_i),
		.bus_wdata_i(bus_wdata_i),
		.layer_done_i(layer_done),
		.bus_rdata_o(bus_rdata_o),
		.width_o(width),
		.height_o(height),
		.start_up_o(start_up),
		.hsync_o(hsync),
		.act_type_o(act_type),
		.act_shift_o(act_shift),
		.weights_o(weights),
		.start_o(start),
		.img_we_o(img_we),
		.img_waddr_o(img_waddr),
		.img_wdata_o(img_wdata)
	);

	cnn_layer_fsm u_layer_fsm (
		.clk(clk),
		.rstn(rstn),
		.start_i(start),
		.delay_end_i(delay_end),
		.frame_end_i(frame_end),
		.state_o(state),
		.layer_done_o(layer_done)
	);

	cnn_scan_counter u_scan_counter (
		.clk(clk),
		.rstn(rstn),
		.state_i(state),
		.width_i(width),
		.height_i(height),
		.start_up_i(start_up),
		.hsync_i(hsync),
		.delay_end_o(delay_end),
		.frame_end_o(frame_end),
		.row_o(row),
		.col_o(col),
		.tap_o(tap),
		.tap_vld_o(tap_vld),
		.first_row_o(first_row),
		.last_row_o(last_row),
		.first_col_o(first_col),
		.last_col_o(last_col)
	);

	cnn_img_buf u_img_buf (
		.clk(clk),
		.rstn(rstn),
		.we_i(img_we),
		.waddr_i(img_waddr),
		.wdata_i(img_wdata),
		.row_i(row),
		.col_i(col),
		.tap_i(tap),
		.tap_vld_i(tap_vld),
		.width_i(width),
		.first_row_i(first_row),
		.last_row_i(last_row),
		.first_col_i(first_col),
		.last_col_i(last_col),
		.tap_pix_o(tap_pix),
		.tap_o(tap_d),
		.tap_vld_o(tap_vld_d)
	);

	cnn_conv_mac u_conv_mac (
		.clk(clk),
		.rstn(rstn),
		.tap_pix_i(tap_pix),
		.tap_i(tap_d),
		.tap_vld_i(tap_vld_d),
		.weights_i(weights),
		.act_type_i(act_type),
		.act_shift_i(act_shift),
		.out_pixel_o(out_pixel_o),
		.out_valid_o(out_valid_o)
	);

endmodule

//--- verilog/cnn_conv_mac.sv
module cnn_conv_mac (
	input  logic clk,
	input  logic rstn,
	input  logic [cnn_dp_pkg::PIX_W-1:0] tap_pix_i,
	input  logic [cnn_dp_pkg::TAP_W-1:0] tap_i,
	input  logic tap_vld_i,
	input  logic [cnn_dp_pkg::N_TAPS*cnn_dp_pkg::WGT_W-1:0] weights_i,
	input  cnn_dp_pkg::act_type_e act_type_i,
	input  logic [cnn_reg_pkg::SHIFT_W-1:0] act_shift_i,
	output logic [cnn_dp_pkg::PIX_W-1:0] out_pixel_o,
	output logic out_valid_o
);

	logic signed [cnn_dp_pkg::WGT_W-1:0] wgt;
	logic signed [cnn_dp_pkg::PIX_W+cnn_dp_pkg::WGT_W:0] prod;
	logic signed [cnn_dp_pkg::ACC_W-1:0] acc_q;
	logic signed [cnn_dp_pkg::ACC_W-1:0] sum;
	logic signed [cnn_dp_pkg::ACC_W-1:0] shifted;
	logic [cnn_dp_pkg::PIX_W-1:0] sat;
	logic tap_last;

	// ----------------------------------------
	// multiply-accumulate
	// ----------------------------------------
	assign wgt = weights_i[tap_i*cnn_dp_pkg::WGT_W +: cnn_dp_pkg::WGT_W];
	// pixel zero-extended and weight sign-extended to product width
	assign prod = $signed({{cnn_dp_pkg::WGT_W{1'b0}}, 1'b0, tap_pix_i}) *
		$signed({{(cnn_dp_pkg::PIX_W+1){wgt[cnn_dp_pkg::WGT_W-1]}}, wgt});
	// tap 0 starts a fresh sum
	assign sum = (tap_i == '0) ? cnn_dp_pkg::ACC_W'(prod) : acc_q + cnn_dp_pkg::ACC_W'(prod);
	assign tap_last = tap_vld_i && (tap_i == cnn_dp_pkg::TAP_W'(cnn_dp_pkg::N_TAPS - 1));

	always_ff @(posedge clk) begin
		if (tap_vld_i)
			acc_q <= sum;
		if (tap_last)
			out_pixel_o <= sat;
	end

	// ----------------------------------------
	// shift and saturate
	// ----------------------------------------
	assign shifted = sum >>> act_shift_i;

	always_comb begin
		if (act_type_i == cnn_dp_pkg::ACT_RELU) begin
			// unsigned 0..255
			if (shifted < 0)
				sat = '0;
			else if (shifted > 255)
				sat = 8'hff;
			else
				sat = shifted[cnn_dp_pkg::PIX_W-1:0];
		end else begin
			// two's complement -128..127
			if (shifted < -128)
				sat = 8'h80;
			else if (shifted > 127)
				sat = 8'h7f;
			else
				sat = shifted[cnn_dp_pkg::PIX_W-1:0];
		end
	end

	// result valid the cycle after the last tap lands
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			out_valid_o <= 1'b0;
		else
			out_valid_o <= tap_last;
	end

endmodule

//--- verilog/cnn_dp_pkg.sv
package cnn_dp_pkg;

	// ----------------------------------------
	// datapath widths
	// ----------------------------------------
	// pixels unsigned, weights signed
	localparam int PIX_W = 8;
	localparam int WGT_W = 8;
	localparam int N_TAPS = 9;
	localparam int TAP_W = $clog2(N_TAPS);
	localparam int ACC_W = 20;

	// image limits
	localparam int MAX_DIM = 32;
	localparam int DIM_W = $clog2(MAX_DIM + 1);
	localparam int IMG_DEPTH = MAX_DIM * MAX_DIM;
	localparam int IMG_ADDR_W = $clog2(IMG_DEPTH);

	// cycles to flush the read and mac stages
	localparam int DRAIN_LEN = 3;

	typedef enum logic [2:0] {
		IDLE,
		START_UP,
		ROW_GAP,
		DATA,
		DRAIN,
		DONE
	} layer_state_e;

	typedef enum logic {
		ACT_RELU = 1'b0,
		ACT_LINEAR = 1'b1
	} act_type_e;

endpackage

//--- verilog/cnn_img_buf.sv
module cnn_img_buf (
	input  logic clk,
	input  logic rstn,
	input  logic we_i,
	input  logic [cnn_dp_pkg::IMG_ADDR_W-1:0] waddr_i,
	input  logic [cnn_dp_pkg::PIX_W-1:0] wdata_i,
	input  logic [cnn_dp_pkg::DIM_W-1:0] row_i,
	input  logic [cnn_dp_pkg::DIM_W-1:0] col_i,
	input  logic [cnn_dp_pkg::TAP_W-1:0] tap_i,
	input  logic tap_vld_i,
	input  logic [cnn_dp_pkg::DIM_W-1:0] width_i,
	input  logic first_row_i,
	input  logic last_row_i,
	input  logic first_col_i,
	input  logic last_col_i,
	output logic [cnn_dp_pkg::PIX_W-1:0] tap_pix_o,
	output logic [cnn_dp_pkg::TAP_W-1:0] tap_o,
	output logic tap_vld_o
);

	logic [cnn_dp_pkg::PIX_W-1:0] mem [cnn_dp_pkg::IMG_DEPTH];
	logic [cnn_dp_pkg::IMG_ADDR_W-1:0] w_ext;
	logic [cnn_dp_pkg::IMG_ADDR_W-1:0] centre;
	logic [cnn_dp_pkg::IMG_ADDR_W-1:0] raddr;
	logic [cnn_dp_pkg::PIX_W-1:0] rd_q;
	logic fr_q;
	logic lr_q;
	logic fc_q;
	logic lc_q;
	logic pad;

	// ----------------------------------------
	// neighbour address
	// ----------------------------------------
	assign w_ext = cnn_dp_pkg::IMG_ADDR_W'(width_i);
	assign centre = cnn_dp_pkg::IMG_ADDR_W'(row_i) * w_ext + cnn_dp_pkg::IMG_ADDR_W'(col_i);

	// taps 0..8 walk the window row by row
	always_comb begin
		case (tap_i)
			4'd0: raddr = centre - w_ext - 1'b1;
			4'd1: raddr = centre - w_ext;
			4'd2: raddr = centre - w_ext + 1'b1;
			4'd3: raddr = centre - 1'b1;
			4'd5: raddr = centre + 1'b1;
			4'd6: raddr = centre + w_ext - 1'b1;
			4'd7: raddr = centre + w_ext;
			4'd8: raddr = centre + w_ext + 1'b1;
			default: raddr = centre;
		endcase
	end

	// host write, synchronous read
	always_ff @(posedge clk) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
		rd_q <= mem[raddr];
	end

	// tap and edge flags follow the read by one cycle
	always_ff @(posedge clk) begin
		tap_o <= tap_i;
		fr_q <= first_row_i;
		lr_q <= last_row_i;
		fc_q <= first_col_i;
		lc_q <= last_col_i;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			tap_vld_o <= 1'b0;
		else
			tap_vld_o <= tap_vld_i;
	end

	// ----------------------------------------
	// zero padding outside the frame
	// ----------------------------------------
	always_comb begin
		case (tap_o)
			4'd0: pad = fr_q | fc_q;
			4'd1: pad = fr_q;
			4'd2: pad = fr_q | lc_q;
			4'd3: pad = fc_q;
			4'd4: pad = 1'b0;
			4'd5: pad = lc_q;
			4'd6: pad = lr_q | fc_q;
			4'd7: pad = lr_q;
			4'd8: pad = lr_q | lc_q;
			default: pad = 1'b1;
		endcase
	end

	assign tap_pix_o = pad ? '0 : rd_q;

endmodule

//--- verilog/cnn_layer_fsm.sv
module cnn_layer_fsm (
	input  logic clk,
	input  logic rstn,
	input  logic start_i,
	input  logic delay_end_i,
	input  logic frame_end_i,
	output cnn_dp_pkg::layer_state_e state_o,
	output logic layer_done_o
);

	cnn_dp_pkg::layer_state_e state_d;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_d = state_o;
		case (state_o)
			// start only honoured here
			cnn_dp_pkg::IDLE: begin
				if (start_i)
					state_d = cnn_dp_pkg::START_UP;
			end
			cnn_dp_pkg::START_UP: begin
				if (delay_end_i)
					state_d = cnn_dp_pkg::ROW_GAP;
			end
			cnn_dp_pkg::ROW_GAP: begin
				if (delay_end_i)
					state_d = cnn_dp_pkg::DATA;
			end
			// end strobe here means last tap of last column
			cnn_dp_pkg::DATA: begin
				if (delay_end_i)
					state_d = frame_end_i ? cnn_dp_pkg::DRAIN : cnn_dp_pkg::ROW_GAP;
			end
			cnn_dp_pkg::DRAIN: begin
				if (delay_end_i)
					state_d = cnn_dp_pkg::DONE;
			end
			cnn_dp_pkg::DONE: state_d = cnn_dp_pkg::IDLE;
			default: state_d = cnn_dp_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			state_o <= cnn_dp_pkg::IDLE;
		else
			state_o <= state_d;
	end

	// one cycle in DONE gives the pulse
	assign layer_done_o = (state_o == cnn_dp_pkg::DONE);

endmodule

//--- verilog/cnn_reg_bank.sv
module cnn_reg_bank (
	input  logic clk,
	input  logic rstn,
	input  logic bus_wr_i,
	input  logic [cnn_reg_pkg::BUS_ADDR_W-1:0] bus_addr_i,
	input  logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_wdata_i,
	input  logic layer_done_i,
	output logic [cnn_reg_pkg::BUS_DATA_W-1:0] bus_rdata_o,
	output logic [cnn_dp_pkg::DIM_W-1:0] width_o,
	output logic [cnn_dp_pkg::DIM_W-1:0] height_o,
	output logic [cnn_reg_pkg::DELAY_W-1:0] start_up_o,
	output logic [cnn_reg_pkg::DELAY_W-1:0] hsync_o,
	output cnn_dp_pkg::act_type_e act_type_o,
	output logic [cnn_reg_pkg::SHIFT_W-1:0] act_shift_o,
	output logic [cnn_dp_pkg::N_TAPS*cnn_dp_pkg::WGT_W-1:0] weights_o,
	output logic start_o,
	output logic img_we_o,
	output logic [cnn_dp_pkg::IMG_ADDR_W-1:0] img_waddr_o,
	output logic [cnn_dp_pkg::PIX_W-1:0] img_wdata_o
);

	logic img_sel;
	logic reg_wr;
	logic start_wr;
	logic done_q;
	cnn_reg_pkg::reg_addr_e reg_idx;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	assign img_sel = bus_addr_i[cnn_reg_pkg::IMG_SEL_BIT];
	assign reg_idx = cnn_reg_pkg::reg_addr_e'(bus_addr_i[cnn_reg_pkg::REG_IDX_W-1:0]);
	assign reg_wr = bus_wr_i & ~img_sel;
	assign start_wr = reg_wr && (reg_idx == cnn_reg_pkg::REG_START) && bus_wdata_i[0];

	// pixel writes go straight to the buffer
	assign img_we_o = bus_wr_i & img_sel;
	assign img_waddr_o = bus_addr_i[cnn_dp_pkg::IMG_ADDR_W-1:0];
	assign img_wdata_o = bus_wdata_i[cnn_dp_pkg::PIX_W-1:0];

	// config registers
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			width_o <= cnn_dp_pkg::DIM_W'(cnn_reg_pkg::DEF_WIDTH);
			height_o <= cnn_dp_pkg::DIM_W'(cnn_reg_pkg::DEF_HEIGHT);
			start_up_o <= cnn_reg_pkg::DELAY_W'(cnn_reg_pkg::DEF_START_UP);
			hsync_o <= cnn_reg_pkg::DELAY_W'(cnn_reg_pkg::DEF_HSYNC);
			act_type_o <= cnn_dp_pkg::ACT_RELU;
			act_shift_o <= '0;
			weights_o <= '0;
		end else if (reg_wr) begin
			case (reg_idx)
				cnn_reg_pkg::REG_WIDTH_HEIGHT: begin
					width_o <= bus_wdata_i[cnn_dp_pkg::DIM_W-1:0];
					height_o <= bus_wdata_i[cnn_reg_pkg::HEIGHT_LSB +: cnn_dp_pkg::DIM_W];
				end
				cnn_reg_pkg::REG_DELAYS: begin
					start_up_o <= bus_wdata_i[cnn_reg_pkg::DELAY_W-1:0];
					hsync_o <= bus_wdata_i[cnn_reg_pkg::HSYNC_LSB +: cnn_reg_pkg::DELAY_W];
				end
				cnn_reg_pkg::REG_LAYER_CFG: begin
					act_type_o <= cnn_dp_pkg::act_type_e'(bus_wdata_i[0]);
					act_shift_o <= bus_wdata_i[cnn_reg_pkg::SHIFT_LSB +: cnn_reg_pkg::SHIFT_W];
				end
				// four weights per word, tap 0 in the low byte
				cnn_reg_pkg::REG_WEIGHT_LO: begin
					weights_o[0 +: 4*cnn_dp_pkg::WGT_W] <= bus_wdata_i;
				end
				cnn_reg_pkg::REG_WEIGHT_HI: begin
					weights_o[4*cnn_dp_pkg::WGT_W +: 4*cnn_dp_pkg::WGT_W] <= bus_wdata_i;
				end
				cnn_reg_pkg::REG_WEIGHT_CTR: begin
					weights_o[8*cnn_dp_pkg::WGT_W +: cnn_dp_pkg::WGT_W] <=
						bus_wdata_i[cnn_dp_pkg::WGT_W-1:0];
				end
				default: begin
				end
			endcase
		end
	end

	// ----------------------------------------
	// start pulse and done flag
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			start_o <= 1'b0;
			done_q <= 1'b0;
		end else begin
			start_o <= start_wr;
			// a new start wins over a finishing layer
			if (start_wr)
				done_q <= 1'b0;
			else if (layer_done_i)
				done_q <= 1'b1;
		end
	end

	// read-back, no side effects
	always_comb begin
		bus_rdata_o = '0;
		if (!img_sel) begin
			case (reg_idx)
				cnn_reg_pkg::REG_WIDTH_HEIGHT: begin
					bus_rdata_o[cnn_dp_pkg::DIM_W-1:0] = width_o;
					bus_rdata_o[cnn_reg_pkg::HEIGHT_LSB +: cnn_dp_pkg::DIM_W] = height_o;
				end
				cnn_reg_pkg::REG_DELAYS: begin
					bus_rdata_o[cnn_reg_pkg::DELAY_W-1:0] = start_up_o;
					bus_rdata_o[cnn_reg_pkg::HSYNC_LSB +: cnn_reg_pkg::DELAY_W] = hsync_o;
				end
				cnn_reg_pkg::REG_LAYER_CFG: begin
					bus_rdata_o[0] = act_type_o;
					bus_rdata_o[cnn_reg_pkg::SHIFT_LSB +: cnn_reg_pkg::SHIFT_W] = act_shift_o;
				end
				cnn_reg_pkg::REG_WEIGHT_LO: bus_rdata_o = weights_o[0 +: 32];
				cnn_reg_pkg::REG_WEIGHT_HI: bus_rdata_o = weights_o[32 +: 32];
				cnn_reg_pkg::REG_WEIGHT_CTR: begin
					bus_rdata_o[cnn_dp_pkg::WGT_W-1:0] = weights_o[64 +: cnn_dp_pkg::WGT_W];
				end
				cnn_reg_pkg::REG_DONE: bus_rdata_o[0] = done_q;
				default: begin
				end
			endcase
		end
	end

endmodule

//--- verilog/cnn_reg_pkg.sv
package cnn_reg_pkg;

	// ----------------------------------------
	// host port geometry
	// ----------------------------------------
	localparam int BUS_ADDR_W = 11;
	localparam int BUS_DATA_W = 32;
	// set: image buffer, clear: register file
	localparam int IMG_SEL_BIT = 10;
	localparam int REG_IDX_W = 4;

	// field widths
	localparam int DELAY_W = 12;
	localparam int SHIFT_W = 4;

	// field offsets inside the data word
	localparam int HEIGHT_LSB = 16;
	localparam int HSYNC_LSB = 12;
	localparam int SHIFT_LSB = 1;

	// reset values
	localparam int DEF_WIDTH = 8;
	localparam int DEF_HEIGHT = 8;
	localparam int DEF_START_UP = 20;
	localparam int DEF_HSYNC = 6;

	// ----------------------------------------
	// register indices
	// ----------------------------------------
	typedef enum logic [REG_IDX_W-1:0] {
		REG_WIDTH_HEIGHT = 4'd0,
		REG_DELAYS = 4'd1,
		REG_LAYER_CFG = 4'd2,
		REG_WEIGHT_LO = 4'd3,
		REG_WEIGHT_HI = 4'd4,
		REG_WEIGHT_CTR = 4'd5,
		REG_START = 4'd6,
		REG_DONE = 4'd7
	} reg_addr_e;

endpackage

//--- verilog/cnn_scan_counter.sv
module cnn_scan_counter (
	input  logic clk,
	input  logic rstn,
	input  cnn_dp_pkg::layer_state_e state_i,
	input  logic [cnn_dp_pkg::DIM_W-1:0] width_i,
	input  logic [cnn_dp_pkg::DIM_W-1:0] height_i,
	input  logic [cnn_reg_pkg::DELAY_W-1:0] start_up_i,
	input  logic [cnn_reg_pkg::DELAY_W-1:0] hsync_i,
	output logic delay_end_o,
	output logic frame_end_o,
	output logic [cnn_dp_pkg::DIM_W-1:0] row_o,
	output logic [cnn_dp_pkg::DIM_W-1:0] col_o,
	output logic [cnn_dp_pkg::TAP_W-1:0] tap_o,
	output logic tap_vld_o,
	output logic first_row_o,
	output logic last_row_o,
	output logic first_col_o,
	output logic last_col_o
);

	logic [cnn_reg_pkg::DELAY_W-1:0] timer_q;
	logic [cnn_reg_pkg::DELAY_W-1:0] delay_lim;
	logic in_delay;
	logic timer_end;
	logic tap_last;
	logic row_end;

	// ----------------------------------------
	// delay timer
	// ----------------------------------------
	always_comb begin
		delay_lim = '0;
		in_delay = 1'b1;
		case (state_i)
			cnn_dp_pkg::START_UP: delay_lim = start_up_i;
			cnn_dp_pkg::ROW_GAP: delay_lim = hsync_i;
			cnn_dp_pkg::DRAIN: delay_lim = cnn_reg_pkg::DELAY_W'(cnn_dp_pkg::DRAIN_LEN);
			default: in_delay = 1'b0;
		endcase
	end

	// zero delay still costs one cycle
	assign timer_end = in_delay &&
		(({1'b0, timer_q} + 1'b1) >= {1'b0, delay_lim});

	// restarts at zero for each new state
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			timer_q <= '0;
		else if (!in_delay || timer_end)
			timer_q <= '0;
		else
			timer_q <= timer_q + 1'b1;
	end

	// ----------------------------------------
	// raster scan, tap fastest
	// ----------------------------------------
	assign tap_vld_o = (state_i == cnn_dp_pkg::DATA);
	assign tap_last = (tap_o == cnn_dp_pkg::TAP_W'(cnn_dp_pkg::N_TAPS - 1));

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			row_o <= '0;
			col_o <= '0;
			tap_o <= '0;
		end else if (state_i == cnn_dp_pkg::IDLE) begin
			row_o <= '0;
			col_o <= '0;
			tap_o <= '0;
		end else if (tap_vld_o) begin
			if (!tap_last) begin
				tap_o <= tap_o + 1'b1;
			end else begin
				tap_o <= '0;
				if (last_col_o) begin
					col_o <= '0;
					row_o <= last_row_o ? '0 : row_o + 1'b1;
				end else begin
					col_o <= col_o + 1'b1;
				end
			end
		end
	end

	// frame edges
	assign first_row_o = (row_o == '0);
	assign last_row_o = (row_o == height_i - 1'b1);
	assign first_col_o = (col_o == '0);
	assign last_col_o = (col_o == width_i - 1'b1);

	// end strobes back to the FSM
	assign row_end = tap_vld_o && tap_last && last_col_o;
	assign delay_end_o = timer_end | row_end;
	assign frame_end_o = row_end & last_row_o;

endmodule
